// File: src/enc_types_pkg.sv
`default_nettype none

package enc_types_pkg;

  localparam int POS_W   = 64;          // Position accumulator width
  localparam int MULT_W  = 8;           // Counts per edge, unsigned
  localparam int DELTA_W = MULT_W + 1;  // Room for negated max multiplier
  localparam int SPEED_W = 32;          // Per-window sum width

  // Accumulated position in counts, signed
  typedef logic signed [POS_W-1:0]   pos_t;

  typedef logic        [MULT_W-1:0]  mult_t;   // Added per quadrature edge
  typedef logic signed [DELTA_W-1:0] delta_t;  // Plus or minus multiplier
  typedef logic signed [SPEED_W-1:0] speed_t;  // Counts per window

endpackage

`default_nettype wire

// File: src/enc_config_pkg.sv
`default_nettype none

package enc_config_pkg;

  // Synchronizer flops per input channel
  // Anything past 3 only adds latency
  localparam int SYNC_STAGES_DEFAULT = 3;

  // Speed sample period in clock cycles
  localparam int SPEED_WINDOW_DEFAULT = 1000;

endpackage

`default_nettype wire

// File: src/quad_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module quad_decoder #(
  parameter int SYNC_STAGES = enc_config_pkg::SYNC_STAGES_DEFAULT  // Flops per channel, min 3
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  a,            // Raw channel A
  input  logic                  b,            // Raw channel B
  input  enc_types_pkg::mult_t  multiplier,   // Static while idle
  output enc_types_pkg::pos_t   position,     // Scaled count
  output logic                  faultn,       // Sticky until reset
  output logic                  step_strobe,  // One pulse per counted edge
  output enc_types_pkg::delta_t step_delta    // Valid with step_strobe
);

  import enc_types_pkg::*;

  localparam int NEW = SYNC_STAGES - 2;  // Newest compared stage
  localparam int OLD = SYNC_STAGES - 1;  // One sample older

  logic [SYNC_STAGES-1:0] a_sync;  // Bit 0 samples the pin
  logic [SYNC_STAGES-1:0] b_sync;
  logic                   step_a;     // A moved this sample
  logic                   step_b;     // B moved this sample
  logic                   step;       // Exactly one channel moved
  logic                   direction;  // High when A leads B
  delta_t                 increment;  // Signed scaled step

  always_ff @(posedge clk) begin
    a_sync <= {a_sync[SYNC_STAGES-2:0], a};  // Shift A toward OLD
    b_sync <= {b_sync[SYNC_STAGES-2:0], b};  // Shift B toward OLD
  end

  assign step_a = a_sync[NEW] ^ a_sync[OLD];  // Edge on A
  assign step_b = b_sync[NEW] ^ b_sync[OLD];  // Edge on B
  assign step   = step_a ^ step_b;            // Both at once is not a step

  // Current A against previous B gives the rotation sense
  assign direction = a_sync[NEW] ^ b_sync[OLD];

  assign increment = direction ? delta_t'({1'b0, multiplier})     // Up
                               : -delta_t'({1'b0, multiplier});   // Down

  always_ff @(posedge clk) begin
    if (!resetn) begin
      position    <= '0;
      faultn      <= 1'b1;
      step_strobe <= 1'b0;
    end else begin
      step_strobe <= step;  // Same edge as the count update
      if (step_a & step_b) begin
        faultn <= 1'b0;  // Direction unknown, latch fault
      end
      if (step) begin
        position <= position + pos_t'(increment);  // Sign-extended add
      end
    end
  end

  always_ff @(posedge clk) begin
    step_delta <= increment;  // Sampled by speed path with strobe
  end

endmodule

`default_nettype wire

// File: src/index_latch.sv
`timescale 1ns/10ps
`default_nettype none

module index_latch #(
  parameter int SYNC_STAGES = enc_config_pkg::SYNC_STAGES_DEFAULT  // Match decoder depth
) (
  input  logic                clk,
  input  logic                resetn,
  input  logic                z,               // Raw index channel
  input  enc_types_pkg::pos_t position,        // Live count from decoder
  output enc_types_pkg::pos_t index_position,  // Count at last index
  output logic                index_strobe,    // One pulse per capture
  output logic                index_seen       // Sticky until reset
);

  logic [SYNC_STAGES-1:0] z_sync;  // Bit 0 samples the pin
  logic                   z_rise;  // Rising edge at chain end

  always_ff @(posedge clk) begin
    z_sync <= {z_sync[SYNC_STAGES-2:0], z};  // Same depth as A/B
  end

  // Seen at the same edge the decoder would count an A/B change
  assign z_rise = z_sync[SYNC_STAGES-2] & ~z_sync[SYNC_STAGES-1];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      index_position <= '0;
      index_strobe   <= 1'b0;
      index_seen     <= 1'b0;
    end else begin
      index_strobe <= z_rise;  // Marks a fresh capture
      if (z_rise) begin
        index_position <= position;  // Value present at this edge
        index_seen     <= 1'b1;      // Stays set
      end
    end
  end

endmodule

`default_nettype wire

// File: src/speed_estimator.sv
`timescale 1ns/10ps
`default_nettype none

module speed_estimator #(
  parameter int SPEED_WINDOW = enc_config_pkg::SPEED_WINDOW_DEFAULT  // Cycles per sample
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  step_strobe,   // Counted edge this cycle
  input  enc_types_pkg::delta_t step_delta,    // Increment for that edge
  output enc_types_pkg::speed_t speed,         // Net counts in last window
  output logic                  speed_strobe   // One pulse per window
);

  import enc_types_pkg::*;

  localparam int CNT_W = (SPEED_WINDOW > 1) ? $clog2(SPEED_WINDOW) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(SPEED_WINDOW - 1);  // Wrap value

  typedef enum logic {
    ST_RUN,      // Accumulating
    ST_PUBLISH   // Window end
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] win_cnt;   // Free-running cycle count
  speed_t           acc;       // Running sum this window
  speed_t           delta_in;  // Strobed increment or zero
  speed_t           total;     // Sum including this cycle

  assign state    = (win_cnt == LAST) ? ST_PUBLISH : ST_RUN;
  assign delta_in = step_strobe ? speed_t'(step_delta) : '0;  // Sign-extended
  assign total    = acc + delta_in;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      win_cnt <= '0;
    end else if (state == ST_PUBLISH) begin
      win_cnt <= '0;  // Wrap
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc          <= '0;
      speed        <= '0;
      speed_strobe <= 1'b0;
    end else begin
      case (state)
        ST_PUBLISH: begin
          speed        <= total;  // Includes a step in the wrap cycle
          speed_strobe <= 1'b1;
          acc          <= '0;     // Next window starts empty
        end
        default: begin
          acc          <= total;
          speed_strobe <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/encoder_axis.sv
`timescale 1ns/10ps
`default_nettype none

module encoder_axis #(
  parameter int SYNC_STAGES  = enc_config_pkg::SYNC_STAGES_DEFAULT,   // Min 3
  parameter int SPEED_WINDOW = enc_config_pkg::SPEED_WINDOW_DEFAULT   // Cycles
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  a,               // Encoder channel A
  input  logic                  b,               // Encoder channel B
  input  logic                  z,               // Index channel
  input  enc_types_pkg::mult_t  multiplier,      // Change only while idle
  output enc_types_pkg::pos_t   position,        // Live scaled count
  output logic                  faultn,          // Low after double change
  output enc_types_pkg::pos_t   index_position,  // Count at last index
  output logic                  index_strobe,    // Capture pulse
  output logic                  index_seen,      // Any index since reset
  output enc_types_pkg::speed_t speed,           // Counts per window
  output logic                  speed_strobe     // New speed value
);

  import enc_types_pkg::*;

  logic   step_strobe;  // Decoder to speed path
  delta_t step_delta;

  quad_decoder #(
    .SYNC_STAGES (SYNC_STAGES)
  ) decoder_i (
    .clk         (clk),
    .resetn      (resetn),
    .a           (a),
    .b           (b),
    .multiplier  (multiplier),
    .position    (position),     // Also feeds index capture
    .faultn      (faultn),
    .step_strobe (step_strobe),
    .step_delta  (step_delta)
  );

  index_latch #(
    .SYNC_STAGES (SYNC_STAGES)   // Keeps Z aligned with A/B
  ) index_i (
    .clk            (clk),
    .resetn         (resetn),
    .z              (z),
    .position       (position),
    .index_position (index_position),
    .index_strobe   (index_strobe),
    .index_seen     (index_seen)
  );

  speed_estimator #(
    .SPEED_WINDOW (SPEED_WINDOW)
  ) speed_i (
    .clk          (clk),
    .resetn       (resetn),
    .step_strobe  (step_strobe),
    .step_delta   (step_delta),
    .speed        (speed),
    .speed_strobe (speed_strobe)
  );

endmodule

`default_nettype wire

// File: test/tb_encoder_axis.sv
`timescale 1ns/10ps
`default_nettype none

module tb_encoder_axis;

  import enc_types_pkg::*;
  import enc_config_pkg::*;

  localparam int SYNC_STAGES  = SYNC_STAGES_DEFAULT;
  localparam int SPEED_WINDOW = 64;                     // Short windows keep runs short
  localparam int NAME_W       = 8 * 24;                 // Up to 24 name characters
  localparam logic [NAME_W-1:0] COMMENT_TOKEN = NAME_W'("#");

  logic   clk;
  logic   resetn;
  logic   a;
  logic   b;
  logic   z;
  mult_t  multiplier;
  pos_t   position;
  logic   faultn;
  pos_t   index_position;
  logic   index_strobe;
  logic   index_seen;
  speed_t speed;
  logic   speed_strobe;

  integer            seed         = 32'hd00cc9a2;  // Random move generator
  longint            speed_sum    = 0;             // Every published speed added up
  longint            last_speed   = 0;
  int                strobe_count = 0;
  int                phase;         // Position in the Gray sequence
  int                errors;        // Errors in the running test
  int                tests_passed;
  int                tests_failed;
  longint            exp_pos;       // Model of the position count
  longint            pos_base;      // Model position at speed start
  longint            sum_base;      // Speed sum at speed start
  logic [NAME_W-1:0] cur_name;
  logic [7:0]        cmd;
  longint            arg;

  encoder_axis #(
    .SYNC_STAGES  (SYNC_STAGES),
    .SPEED_WINDOW (SPEED_WINDOW)
  ) dut_i (
    .clk            (clk),
    .resetn         (resetn),
    .a              (a),
    .b              (b),
    .z              (z),
    .multiplier     (multiplier),
    .position       (position),
    .faultn         (faultn),
    .index_position (index_position),
    .index_strobe   (index_strobe),
    .index_seen     (index_seen),
    .speed          (speed),
    .speed_strobe   (speed_strobe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Outputs settle after the rising edge and are taken on the falling one
  always @(negedge clk) begin
    if (speed_strobe) begin
      speed_sum    = speed_sum + longint'(speed);
      last_speed   = longint'(speed);
      strobe_count = strobe_count + 1;
    end
  end

  // Quadrature state as {b, a} with A leading B when counting up
  function automatic logic [1:0] gray_code(input int p);
    case (p)
      0:       gray_code = 2'b00;
      1:       gray_code = 2'b01;
      2:       gray_code = 2'b11;
      default: gray_code = 2'b10;
    endcase
  endfunction

  task automatic check_equal(input string label, input longint expected,
                             input longint actual);
    if (expected !== actual) begin
      $display("MISMATCH %0s %0s: expected %0d actual %0d",
               cur_name, label, expected, actual);
      errors++;
    end
  endtask

  task automatic apply_reset;
    @(negedge clk);
    resetn = 1'b0;
    repeat (4) @(negedge clk);  // Four rising edges in reset
    resetn  = 1'b1;
    exp_pos = 0;
  endtask

  task automatic settle;
    repeat (SYNC_STAGES + 1) @(negedge clk);  // Let the last edge pass the sync
  endtask

  task automatic drive_edges(input int count, input logic forward);
    int i;
    for (i = 0; i < count; i++) begin
      @(negedge clk);
      phase = forward ? (phase + 1) % 4 : (phase + 3) % 4;
      {b, a} = gray_code(phase);
      if (forward) begin
        exp_pos = exp_pos + longint'(multiplier);
      end else begin
        exp_pos = exp_pos - longint'(multiplier);
      end
      repeat (3) @(negedge clk);  // One edge every 4 cycles
    end
  endtask

  task automatic double_change;
    @(negedge clk);
    phase = (phase + 2) % 4;  // Both bits flip, nothing counted
    {b, a} = gray_code(phase);
    repeat (3) @(negedge clk);
  endtask

  task automatic pulse_index;
    int cycles;
    cycles = 0;
    @(negedge clk);
    z = 1'b1;
    while (!index_strobe && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (!index_strobe) begin
      $display("ERROR test %0s: index_strobe never pulsed after raising z", cur_name);
      errors++;
    end else begin
      check_equal("index_seen", longint'(1), longint'(index_seen));
      check_equal("index_capture", exp_pos, index_position);  // No skew while idle
      // Strobe lasts a single cycle
      @(negedge clk);
      check_equal("index_strobe_len", longint'(0), longint'(index_strobe));
    end
    z = 1'b0;
    settle();
  endtask

  task automatic wait_speed_strobes(input int count);
    int target;
    int cycles;
    int limit;
    @(posedge clk);  // Counter is stable here
    target = strobe_count + count;
    limit  = (count + 1) * SPEED_WINDOW + 16;
    cycles = 0;
    while (strobe_count < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (strobe_count < target) begin
      $display("ERROR test %0s: speed_strobe did not arrive %0d times within %0d cycles",
               cur_name, count, limit);
      errors++;
    end
  endtask

  task automatic random_moves(input int count);
    int   i;
    int   len;
    logic fwd;
    for (i = 0; i < count; i++) begin
      len = ($random(seed) & 7) + 1;         // 1 to 8 edges
      fwd = ($random(seed) & 1) != 0;
      drive_edges(len, fwd);
    end
  endtask

  task automatic run_command;
    case (cmd)
      "R": apply_reset();
      "M": begin
        @(negedge clk);
        multiplier = mult_t'(arg);  // Only between moves
      end
      "F": drive_edges(int'(arg), 1'b1);
      "B": drive_edges(int'(arg), 1'b0);
      "X": double_change();
      "I": pulse_index();
      "Q": random_moves(int'(arg));
      "W": wait_speed_strobes(int'(arg));
      "C": begin
        wait_speed_strobes(2);  // Flush windows with older motion
        pos_base = exp_pos;
        sum_base = speed_sum;
      end
      "S": begin
        wait_speed_strobes(2);
        check_equal("speed_sum", exp_pos - pos_base, speed_sum - sum_base);
      end
      "V": begin
        wait_speed_strobes(1);
        check_equal("speed", arg, last_speed);
      end
      "P": begin
        settle();
        check_equal("position", arg, position);
      end
      "T": begin
        settle();
        check_equal("model_position", exp_pos, position);
      end
      "L": begin
        settle();
        check_equal("index_position", arg, index_position);
      end
      "E": begin
        settle();
        check_equal("faultn", arg, longint'(faultn));
      end
      default: begin
        $display("ERROR test %0s: unknown command %0s in test file", cur_name, cmd);
        errors++;
      end
    endcase
  endtask

  task automatic finish_test;
    if (errors == 0) begin
      $display("test %0s: ok", cur_name);
      tests_passed++;
    end else begin
      $display("test %0s: %0d errors", cur_name, errors);
      tests_failed++;
    end
    errors = 0;
  endtask

  initial begin
    int                fd;
    int                code;
    logic              done;
    logic              open_failed;
    logic [NAME_W-1:0] name;
    logic [8*160-1:0]  rest;  // Tail of a comment line
    resetn       = 1'b0;
    a            = 1'b0;
    b            = 1'b0;
    z            = 1'b0;
    multiplier   = 8'd1;
    phase        = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    exp_pos      = 0;
    pos_base     = 0;
    sum_base     = 0;
    cur_name     = '0;
    done         = 1'b0;
    open_failed  = 1'b0;
    fd = $fopen("test/encoder_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open test/encoder_tests.txt");
      open_failed = 1'b1;
    end else begin
      while (!done) begin
        code = $fscanf(fd, "%s", name);
        if (code != 1) begin
          done = 1'b1;  // End of file
        end else if (name == COMMENT_TOKEN) begin
          code = $fgets(rest, fd);
        end else begin
          if (name != cur_name) begin
            if (cur_name != '0) finish_test();
            cur_name = name;
          end
          code = $fscanf(fd, "%s %d", cmd, arg);
          if (code != 2) begin
            $display("ERROR test %0s: line in test file is malformed", cur_name);
            errors++;
          end else begin
            run_command();
          end
        end
      end
      if (cur_name != '0) finish_test();
      $fclose(fd);
    end
    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (!open_failed && tests_failed == 0 && tests_passed > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/encoder_tests.txt
# Columns: test name, command letter, argument in decimal (0 when unused)
# R reset, M multiplier, F forward edges, B backward edges, X A and B change together
# I index pulse, W wait speed strobes, C start speed sum, S check speed sum
# V check last speed, Q random moves, P position, L index position, E faultn
# T position against the testbench model
count_up R 0
count_up P 0
count_up E 1
count_up M 3
count_up F 10
count_up P 30
count_down B 14
count_down P -12
count_down M 200
count_down B 5
count_down P -1012
count_down T 0
mult_change M 7
mult_change F 4
mult_change M 1
mult_change F 9
mult_change M 255
mult_change F 2
mult_change P -465
fault X 0
fault P -465
fault E 0
fault F 3
fault P 300
fault E 0
fault R 0
fault P 0
fault E 1
index L 0
index M 2
index F 6
index I 0
index L 12
index F 5
index P 22
index L 12
index B 20
index I 0
index L -18
speed_fixed C 0
speed_fixed F 40
speed_fixed B 10
speed_fixed S 0
speed_fixed P 42
speed_random M 3
speed_random C 0
speed_random Q 12
speed_random S 0
speed_random T 0
speed_idle W 1
speed_idle V 0

// File: all.f
src/enc_types_pkg.sv
src/enc_config_pkg.sv
src/quad_decoder.sv
src/index_latch.sv
src/speed_estimator.sv
src/encoder_axis.sv
test/tb_encoder_axis.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary -j 0 --top-module tb_encoder_axis -Mdir "$OBJ" -f all.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/Vtb_encoder_axis" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
